//--- source/mulDivPkg.sv
package mulDivPkg;

	// Width of each signed operand
	localparam int operandBits = 8;

	// Engine select carried with each command
	typedef enum logic {
		opMul = 1'b0,
		opDiv = 1'b1
	} opCode;

	// Command tag echoed back with the result
	typedef logic [3:0] cmdTag;

endpackage

//--- source/resultBusPkg.sv
package resultBusPkg;

	// Divider view of the result word
	typedef struct packed {
		logic signed [mulDivPkg::operandBits-1:0] quotient;
		logic signed [mulDivPkg::operandBits-1:0] remainder;
	} divFields;

	// One 16-bit word with two decodings
	typedef union packed {
		logic signed [2*mulDivPkg::operandBits-1:0] product;
		divFields divPart;
	} resultWord;

	// Record offered by an engine and registered by the arbiter
	typedef struct packed {
		resultWord word;
		mulDivPkg::cmdTag tag;
		logic isDiv;
		logic divByZero;
	} engineResult;

endpackage

//--- source/resultBus.sv
`timescale 1ns/100ps

// Link between one engine and the result arbiter
interface resultBus import resultBusPkg::*; (
	input logic clk
);

	// Held high with a stable result until granted
	logic request;
	engineResult result;

	// One-cycle pulse from the arbiter
	logic grant;

	modport engine (
		input clk,
		input grant,
		output request,
		output result
	);

	modport arbiter (
		input clk,
		input request,
		input result,
		output grant
	);

endinterface

//--- source/boothMultiplier.sv
`timescale 1ns/100ps

module boothMultiplier import mulDivPkg::*, resultBusPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic signed [operandBits-1:0] multiplicand,
	input logic signed [operandBits-1:0] multiplier,
	input cmdTag tag,
	output logic ready,
	resultBus.engine bus
);

	localparam int countBits = $clog2(operandBits);

	// FSM encoding
	localparam logic [1:0] idleS = 2'd0;
	localparam logic [1:0] loadS = 2'd1;
	localparam logic [1:0] stepS = 2'd2;
	localparam logic [1:0] offerS = 2'd3;

	logic [1:0] state;
	logic [countBits-1:0] stepCount;
	logic lastStep;

	// One extra bit so that subtracting -128 cannot overflow
	logic signed [operandBits:0] mcandExt;
	logic signed [operandBits:0] mcandNeg;
	logic signed [operandBits:0] acc;
	logic signed [operandBits:0] accSum;

	// Multiplier shifts out low bits while product bits shift in
	logic [operandBits-1:0] mplier;
	logic boothBit;
	logic [2*operandBits-1:0] productNext;

	engineResult resultReg;

	assign lastStep = (stepCount == countBits'(operandBits - 1));

	////////////////////////////////////////////////////////////////////////////
	// Booth recoding of the two low bits
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case ({mplier[0], boothBit})
			2'b01: accSum = acc + mcandExt;
			2'b10: accSum = acc + mcandNeg;
			default: accSum = acc;
		endcase
	end

	// Product after the final arithmetic shift
	assign productNext = {accSum, mplier[operandBits-1:1]};

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idleS;
		end else begin
			case (state)
				idleS: if (start) state <= loadS;
				loadS: state <= stepS;
				stepS: if (lastStep) state <= offerS;
				offerS: if (bus.grant) state <= idleS;
				default: state <= idleS;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		case (state)
			idleS: begin
				// Capture command, busy starts are never seen here
				if (start) begin
					mcandExt <= multiplicand;
					mplier <= multiplier;
					resultReg.tag <= tag;
				end
			end
			loadS: begin
				mcandNeg <= -mcandExt;
				acc <= '0;
				boothBit <= 1'b0;
				stepCount <= '0;
			end
			stepS: begin
				// Add or skip then arithmetic shift right
				acc <= {accSum[operandBits], accSum[operandBits:1]};
				mplier <= {accSum[0], mplier[operandBits-1:1]};
				boothBit <= mplier[0];
				stepCount <= stepCount + 1'b1;
				if (lastStep) begin
					resultReg.word.product <= productNext;
					resultReg.isDiv <= 1'b0;
					resultReg.divByZero <= 1'b0;
				end
			end
			default: ;
		endcase
	end

	assign ready = (state == idleS);
	assign bus.request = (state == offerS);
	assign bus.result = resultReg;

endmodule

//--- source/nonRestoringDivider.sv
`timescale 1ns/100ps

module nonRestoringDivider import mulDivPkg::*, resultBusPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic signed [operandBits-1:0] dividend,
	input logic signed [operandBits-1:0] divisor,
	input cmdTag tag,
	output logic ready,
	resultBus.engine bus
);

	localparam int countBits = $clog2(operandBits);
	// Partial remainder plus shift headroom and sign
	localparam int remW = operandBits + 2;

	// FSM encoding
	localparam logic [2:0] idleS = 3'd0;
	localparam logic [2:0] prepS = 3'd1;
	localparam logic [2:0] stepS = 3'd2;
	localparam logic [2:0] fixS = 3'd3;
	localparam logic [2:0] offerS = 3'd4;

	logic [2:0] state;
	logic [countBits-1:0] stepCount;
	logic lastStep;

	logic signed [operandBits-1:0] dividendReg;
	logic signed [operandBits-1:0] divisorReg;
	logic signA;
	logic signB;
	logic zeroDiv;

	// Magnitudes, 128 still fits unsigned
	logic [operandBits-1:0] dividendAbs;
	logic [operandBits-1:0] divisorAbs;
	logic [remW-1:0] divMag;

	// Dividend bits shift out as quotient bits shift in
	logic [operandBits-1:0] quotBits;
	logic [remW-1:0] partRem;
	logic [remW-1:0] remShift;
	logic [remW-1:0] remNext;

	// Correction and sign restore
	logic [remW-1:0] remFixed;
	logic [operandBits-1:0] quotSigned;
	logic [operandBits-1:0] remSigned;

	engineResult resultReg;

	assign lastStep = (stepCount == countBits'(operandBits - 1));

	////////////////////////////////////////////////////////////////////////////
	// Sign extraction
	////////////////////////////////////////////////////////////////////////////
	assign signA = dividendReg[operandBits-1];
	assign signB = divisorReg[operandBits-1];
	assign dividendAbs = signA ? -dividendReg : dividendReg;
	assign divisorAbs = signB ? -divisorReg : divisorReg;

	// One non-restoring step
	assign remShift = {partRem[remW-2:0], quotBits[operandBits-1]};
	// Add back when the last remainder went negative
	assign remNext = partRem[remW-1] ? remShift + divMag : remShift - divMag;

	// Final correction of a negative remainder
	assign remFixed = partRem[remW-1] ? partRem + divMag : partRem;
	assign quotSigned = (signA ^ signB) ? -quotBits : quotBits;
	// Remainder follows the dividend sign
	assign remSigned = signA ? -remFixed[operandBits-1:0] : remFixed[operandBits-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idleS;
		end else begin
			case (state)
				idleS: if (start) state <= prepS;
				prepS: state <= stepS;
				stepS: if (lastStep) state <= fixS;
				fixS: state <= offerS;
				offerS: if (bus.grant) state <= idleS;
				default: state <= idleS;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		case (state)
			idleS: begin
				if (start) begin
					dividendReg <= dividend;
					divisorReg <= divisor;
					resultReg.tag <= tag;
				end
			end
			prepS: begin
				// Strip signs and flag a zero divisor
				quotBits <= dividendAbs;
				divMag <= {2'b00, divisorAbs};
				zeroDiv <= (divisorReg == '0);
				partRem <= '0;
				stepCount <= '0;
			end
			stepS: begin
				partRem <= remNext;
				// Quotient bit is the inverted new sign
				quotBits <= {quotBits[operandBits-2:0], ~remNext[remW-1]};
				stepCount <= stepCount + 1'b1;
			end
			fixS: begin
				resultReg.isDiv <= 1'b1;
				resultReg.divByZero <= zeroDiv;
				if (zeroDiv) begin
					// All ones quotient, dividend passed back
					resultReg.word.divPart.quotient <= '1;
					resultReg.word.divPart.remainder <= dividendReg;
				end else begin
					resultReg.word.divPart.quotient <= quotSigned;
					resultReg.word.divPart.remainder <= remSigned;
				end
			end
			default: ;
		endcase
	end

	assign ready = (state == idleS);
	assign bus.request = (state == offerS);
	assign bus.result = resultReg;

endmodule

//--- source/resultArbiter.sv
`timescale 1ns/100ps

module resultArbiter import mulDivPkg::*, resultBusPkg::*; (
	input logic clk,
	input logic reset,
	resultBus.arbiter mulBus,
	resultBus.arbiter divBus,
	output logic resultValid,
	output engineResult resultOut
);

	// Engine granted most recently
	opCode lastGranted;
	logic mulWins;

	////////////////////////////////////////////////////////////////////////////
	// Round-robin grant
	////////////////////////////////////////////////////////////////////////////
	// Multiplier wins alone, or on a tie when the divider went last
	assign mulWins = mulBus.request && (!divBus.request || lastGranted == opDiv);
	assign mulBus.grant = mulWins;
	assign divBus.grant = divBus.request && !mulWins;

	// Pointer and valid strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
			lastGranted <= opDiv;
		end else begin
			resultValid <= mulBus.grant || divBus.grant;
			if (mulBus.grant) begin
				lastGranted <= opMul;
			end else if (divBus.grant) begin
				lastGranted <= opDiv;
			end
		end
	end

	// Registered result port
	always_ff @(posedge clk) begin
		if (mulBus.grant) begin
			resultOut <= mulBus.result;
		end else if (divBus.grant) begin
			resultOut <= divBus.result;
		end
	end

endmodule

//--- source/mulDivUnit.sv
`timescale 1ns/100ps

module mulDivUnit import mulDivPkg::*, resultBusPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input opCode op,
	input logic signed [operandBits-1:0] operandA,
	input logic signed [operandBits-1:0] operandB,
	input cmdTag tag,
	output logic mulReady,
	output logic divReady,
	output logic resultValid,
	output cmdTag resultTag,
	output logic resultIsDiv,
	output logic divByZero,
	output logic [operandBits-1:0] resultHigh,
	output logic [operandBits-1:0] resultLow
);

	logic mulStart;
	logic divStart;
	engineResult resultOut;

	resultBus mulLink (.clk(clk));
	resultBus divLink (.clk(clk));

	// Command steering, busy engines drop their own start
	assign mulStart = start && (op == opMul);
	assign divStart = start && (op == opDiv);

	////////////////////////////////////////////////////////////////////////////
	// Engines and shared result port
	////////////////////////////////////////////////////////////////////////////
	boothMultiplier mulEngine0 (
		.clk(clk),
		.reset(reset),
		.start(mulStart),
		.multiplicand(operandA),
		.multiplier(operandB),
		.tag(tag),
		.ready(mulReady),
		.bus(mulLink.engine)
	);

	nonRestoringDivider divEngine0 (
		.clk(clk),
		.reset(reset),
		.start(divStart),
		.dividend(operandA),
		.divisor(operandB),
		.tag(tag),
		.ready(divReady),
		.bus(divLink.engine)
	);

	resultArbiter arbiter0 (
		.clk(clk),
		.reset(reset),
		.mulBus(mulLink.arbiter),
		.divBus(divLink.arbiter),
		.resultValid(resultValid),
		.resultOut(resultOut)
	);

	// Unpack the registered record
	assign resultTag = resultOut.tag;
	assign resultIsDiv = resultOut.isDiv;
	assign divByZero = resultOut.divByZero;
	// Upper half is the quotient for a divide
	assign resultHigh = resultOut.word.product[2*operandBits-1:operandBits];
	assign resultLow = resultOut.word.product[operandBits-1:0];

endmodule

//--- tests/mulDivUnit_assertions.sv
`timescale 1ns/100ps

module mulDivUnit_assertions import resultBusPkg::*; (
	input logic clk,
	input logic reset,
	input logic mulRequest,
	input logic mulGrant,
	input engineResult mulResult,
	input logic divRequest,
	input logic divGrant,
	input engineResult divResult
);

	// Loser of a tie is served on the next cycle
	mulServedAfterTie: assert property (@(posedge clk) disable iff (reset)
		mulRequest && !mulGrant |=> mulGrant)
		else $error("multiplier request waited more than one cycle");

	divServedAfterTie: assert property (@(posedge clk) disable iff (reset)
		divRequest && !divGrant |=> divGrant)
		else $error("divider request waited more than one cycle");

	// Request and record hold until granted
	mulHoldsRequest: assert property (@(posedge clk) disable iff (reset)
		mulRequest && !mulGrant |=> mulRequest && $stable(mulResult))
		else $error("multiplier request or result changed before grant");

	divHoldsRequest: assert property (@(posedge clk) disable iff (reset)
		divRequest && !divGrant |=> divRequest && $stable(divResult))
		else $error("divider request or result changed before grant");

endmodule

bind resultArbiter mulDivUnit_assertions asserts0 (
	.clk(clk),
	.reset(reset),
	.mulRequest(mulBus.request),
	.mulGrant(mulBus.grant),
	.mulResult(mulBus.result),
	.divRequest(divBus.request),
	.divGrant(divBus.grant),
	.divResult(divBus.result)
);

//--- tests/mulDivUnit_tb.sv
`timescale 1ns/100ps

module mulDivUnit_tb import mulDivPkg::*, resultBusPkg::*; ;

	localparam int clkPeriod = 10;
	localparam int resetCycles = 5;
	localparam int directedSlots = 4;
	localparam int randomSlots = 400;
	localparam int cyclesPerCommand = 40;
	// Galois taps for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] lfsrTaps = 32'h8020_0003;

	logic clk;
	logic reset;
	logic start;
	opCode op;
	logic signed [operandBits-1:0] operandA;
	logic signed [operandBits-1:0] operandB;
	cmdTag tag;
	logic mulReady;
	logic divReady;
	logic resultValid;
	cmdTag resultTag;
	logic resultIsDiv;
	logic divByZero;
	logic [operandBits-1:0] resultHigh;
	logic [operandBits-1:0] resultLow;

	logic [31:0] lfsrState;

	// Reference model, one entry per tag
	logic pending [16];
	logic [operandBits-1:0] expHigh [16];
	logic [operandBits-1:0] expLow [16];
	logic expIsDiv [16];
	logic expZero [16];
	int outstanding;
	int mulSeen;
	int divSeen;
	int zeroSeen;

	mulDivUnit dut0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.operandA(operandA),
		.operandB(operandB),
		.tag(tag),
		.mulReady(mulReady),
		.divReady(divReady),
		.resultValid(resultValid),
		.resultTag(resultTag),
		.resultIsDiv(resultIsDiv),
		.divByZero(divByZero),
		.resultHigh(resultHigh),
		.resultLow(resultLow)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Whole run bounded by command count
	initial begin
		#((resetCycles + cyclesPerCommand * (directedSlots + randomSlots)) * clkPeriod);
		$display("Watchdog expired, results stopped arriving from the DUT");
		$display("Test FAILED");
		$fatal(1, "Watchdog timeout");
	end

	////////////////////////////////////////////////////////////////////////////
	// Random source
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		lfsrStep = s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic randomBits(input int n, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	// Corner values 0, -1 and -128 come up often
	task automatic randomOperand(output logic signed [operandBits-1:0] value);
		logic [31:0] pick;
		logic [31:0] bits;
		randomBits(3, pick);
		case (pick[2:0])
			3'd0: value = 8'sd0;
			3'd1: value = -8'sd1;
			3'd2: value = 8'h80;
			default: begin
				randomBits(operandBits, bits);
				value = bits[operandBits-1:0];
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////
	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Retire one result against the model
	task automatic collectResult;
		cmdTag t;
		if (resultValid === 1'b1) begin
			t = resultTag;
			if (!pending[t]) begin
				$display("Result arrived for tag %0d with no command outstanding", t);
				$display("Test FAILED");
				$fatal(1, "Stray result");
			end else begin
				checkValue($sformatf("tag %0d isDiv", t), 16'(expIsDiv[t]), 16'(resultIsDiv));
				checkValue($sformatf("tag %0d divByZero", t), 16'(expZero[t]), 16'(divByZero));
				checkValue($sformatf("tag %0d result", t), {expHigh[t], expLow[t]},
					{resultHigh, resultLow});
				pending[t] = 1'b0;
				outstanding--;
				if (!expIsDiv[t])
					mulSeen++;
				else if (expZero[t])
					zeroSeen++;
				else
					divSeen++;
			end
		end
	endtask

	// One falling edge: retire, then drive and record if accepted
	task automatic driveSlot(input logic issue, input opCode cmdOp,
			input logic signed [operandBits-1:0] a, input logic signed [operandBits-1:0] b,
			input cmdTag wantTag);
		cmdTag t;
		logic engineReady;
		logic signed [15:0] product;
		int quot;
		int rem;
		int i;
		@(negedge clk);
		collectResult();
		// Skip tags still in flight
		t = wantTag;
		for (i = 0; i < 16; i++)
			if (pending[t]) t = t + 1'b1;
		engineReady = (cmdOp == opMul) ? mulReady : divReady;
		start = issue;
		op = cmdOp;
		operandA = a;
		operandB = b;
		tag = t;
		if (issue && engineReady) begin
			pending[t] = 1'b1;
			outstanding++;
			expIsDiv[t] = (cmdOp == opDiv);
			expZero[t] = (cmdOp == opDiv) && (b == 0);
			if (cmdOp == opMul) begin
				product = a * b;
				expHigh[t] = product[15:8];
				expLow[t] = product[7:0];
			end else if (b == 0) begin
				expHigh[t] = 8'hff;
				expLow[t] = a;
			end else begin
				// Truncating division, remainder follows the dividend
				quot = int'(a) / int'(b);
				rem = int'(a) % int'(b);
				expHigh[t] = quot[7:0];
				expLow[t] = rem[7:0];
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] pick;
		logic issue;
		opCode cmdOp;
		logic signed [operandBits-1:0] a;
		logic signed [operandBits-1:0] b;
		int i;
		lfsrState = 32'h1a53_3530;
		reset = 1'b1;
		start = 1'b0;
		op = opMul;
		operandA = '0;
		operandB = '0;
		tag = '0;
		outstanding = 0;
		mulSeen = 0;
		divSeen = 0;
		zeroSeen = 0;
		for (i = 0; i < 16; i++) begin
			pending[i] = 1'b0;
			expHigh[i] = '0;
			expLow[i] = '0;
			expIsDiv[i] = 1'b0;
			expZero[i] = 1'b0;
		end
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;
		checkValue("reset resultValid", 16'd0, 16'(resultValid));
		checkValue("reset mulReady", 16'd1, 16'(mulReady));
		checkValue("reset divReady", 16'd1, 16'(divReady));

		// Both engines then request on the same edge
		driveSlot(1'b1, opDiv, 8'h80, -8'sd1, 4'd1);
		driveSlot(1'b1, opMul, 8'h80, 8'h80, 4'd2);
		// Busy engines drop these
		driveSlot(1'b1, opMul, 8'sd5, 8'sd6, 4'd3);
		driveSlot(1'b1, opDiv, 8'sd100, 8'sd0, 4'd4);

		for (i = 0; i < randomSlots; i++) begin
			randomBits(2, pick);
			issue = (pick[1:0] != 2'd0);
			randomBits(1, pick);
			cmdOp = opCode'(pick[0]);
			randomOperand(a);
			randomOperand(b);
			randomBits(4, pick);
			driveSlot(issue, cmdOp, a, b, pick[3:0]);
		end

		// Drain what is still in flight
		while (outstanding != 0)
			driveSlot(1'b0, opMul, 8'sd0, 8'sd0, 4'd0);

		if (mulSeen == 0 || divSeen == 0 || zeroSeen == 0) begin
			$display("Some result kinds never appeared: mul %0d div %0d zero %0d",
				mulSeen, divSeen, zeroSeen);
			$display("Test FAILED");
			$fatal(1, "Incomplete run");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

//--- filelist.f
source/mulDivPkg.sv
source/resultBusPkg.sv
source/resultBus.sv
source/boothMultiplier.sv
source/nonRestoringDivider.sv
source/resultArbiter.sv
source/mulDivUnit.sv
tests/mulDivUnit_assertions.sv
tests/mulDivUnit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mulDivUnit_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)
